// File: common/spdif_pkg.sv
`default_nettype none

package spdif_pkg;

    // halfbit timing, period input is 6..31 clocks
    localparam int HALFBIT_CNT_W = 5;

    localparam int SAMPLE_W = 24;

    // one channel status block
    localparam int BLOCK_FRAMES = 192;
    localparam int BLOCK_CNT_W = 8;

    // 28 bits after the preamble, two halfbits each
    localparam int SLOTS_PER_SUBFRAME = 56;
    localparam int SLOT_CNT_W = 6;

    localparam logic [SLOT_CNT_W-1:0] SLOT_UNLOCKED = 6'd63; // no preamble seen

    // slot counts at which a bit's second halfbit arrives
    localparam logic [SLOT_CNT_W-1:0] SLOT_FIRST_BIT = 6'd1;
    localparam logic [SLOT_CNT_W-1:0] SLOT_LAST_AUDIO = 6'(2 * SAMPLE_W - 1);
    localparam logic [SLOT_CNT_W-1:0] SLOT_LAST = 6'(SLOTS_PER_SUBFRAME - 1); // P bit

    // extra strobes at saturation before lock drops
    localparam int UNLOCK_CNT_W = 4;
    localparam logic [UNLOCK_CNT_W-1:0] UNLOCK_TOLERANCE = 4'd15;

    // preamble halfbit patterns, oldest halfbit in the msb
    // the complements are valid too, depending on the line level before
    localparam logic [7:0] SYNC_B = 8'b0001_0111;
    localparam logic [7:0] SYNC_W = 8'b0001_1011;
    localparam logic [7:0] SYNC_M = 8'b0001_1101;

    typedef enum logic [1:0] {
        PRE_NONE = 2'd0,
        PRE_B    = 2'd1, // block start, channel A
        PRE_W    = 2'd2, // channel B
        PRE_M    = 2'd3  // channel A
    } preamble_t;

endpackage

`default_nettype wire

// File: logic/spdif_halfbit_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module spdif_halfbit_sampler (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [spdif_pkg::HALFBIT_CNT_W-1:0]  clk_per_halfbit_i,
    input  logic                                 line_i,
    output logic                                 halfbit_stb_o,
    output logic                                 halfbit_lvl_o
);

    logic [3:0]                          line_hist;
    logic                                edge_det;
    logic                                edge_q;
    logic                                slot_end;
    logic                                needle;
    logic                                vote;
    logic [spdif_pkg::HALFBIT_CNT_W-1:0] slot_cnt;
    logic [spdif_pkg::HALFBIT_CNT_W-1:0] high_cnt;

    // also serves as the synchronizer for the async line
    always_ff @(posedge clk) begin
        if (rst) begin
            line_hist <= '0;
        end else begin
            line_hist <= {line_hist[2:0], line_i};
        end
    end

    // two stable samples after two opposite ones
    assign edge_det = (line_hist == 4'b1100) || (line_hist == 4'b0011);

    always_ff @(posedge clk) begin
        if (rst) begin
            edge_q <= 1'b0;
        end else begin
            edge_q <= edge_det;
        end
    end

    assign slot_end = (slot_cnt == clk_per_halfbit_i) || edge_q;
    assign needle   = line_hist[2]; // first new level lines up with edge_q

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt <= '0;
            high_cnt <= '0;
        end else if (slot_end) begin
            slot_cnt <= '0;
            high_cnt <= {{(spdif_pkg::HALFBIT_CNT_W-1){1'b0}}, needle};
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
            if (high_cnt != '1) begin
                high_cnt <= high_cnt + {{(spdif_pkg::HALFBIT_CNT_W-1){1'b0}}, needle};
            end
        end
    end

    // majority over the closing slot
    assign vote = (high_cnt >= (clk_per_halfbit_i >> 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            halfbit_stb_o <= 1'b0;
        end else begin
            halfbit_stb_o <= slot_end;
        end
    end

    always_ff @(posedge clk) begin
        if (slot_end) begin
            halfbit_lvl_o <= vote;
        end
    end

endmodule

`default_nettype wire

// File: spdif_decoder/spdif_frame_sync.sv
`timescale 1ns/1ps
`default_nettype none

module spdif_frame_sync (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              halfbit_stb_i,
    input  logic                              halfbit_lvl_i,
    output logic                              pre_stb_o,
    output spdif_pkg::preamble_t              pre_type_o,
    output logic [spdif_pkg::SLOT_CNT_W-1:0]  slot_cnt_o,
    output logic                              locked_o
);

    logic [7:0]                            hb_hist;
    logic [7:0]                            hist_next;
    spdif_pkg::preamble_t                  match_type;
    logic                                  match;
    logic [spdif_pkg::UNLOCK_CNT_W-1:0]    tol_cnt;

    // window including the halfbit arriving now
    always_comb begin
        hist_next  = {hb_hist[6:0], halfbit_lvl_i};
        match_type = spdif_pkg::PRE_NONE;
        case (hist_next)
            spdif_pkg::SYNC_B, ~spdif_pkg::SYNC_B: match_type = spdif_pkg::PRE_B;
            spdif_pkg::SYNC_W, ~spdif_pkg::SYNC_W: match_type = spdif_pkg::PRE_W;
            spdif_pkg::SYNC_M, ~spdif_pkg::SYNC_M: match_type = spdif_pkg::PRE_M;
            default: match_type = spdif_pkg::PRE_NONE;
        endcase
    end

    assign match = halfbit_stb_i && (match_type != spdif_pkg::PRE_NONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            hb_hist <= '0;
        end else if (halfbit_stb_i) begin
            hb_hist <= hist_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pre_stb_o  <= 1'b0;
            pre_type_o <= spdif_pkg::PRE_NONE;
        end else begin
            pre_stb_o <= match;
            if (match) begin
                pre_type_o <= match_type;
            end
        end
    end

    // halfbits since the last preamble, sticks at SLOT_UNLOCKED
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt_o <= spdif_pkg::SLOT_UNLOCKED;
        end else if (match) begin
            slot_cnt_o <= '0;
        end else if (halfbit_stb_i && slot_cnt_o != spdif_pkg::SLOT_UNLOCKED) begin
            slot_cnt_o <= slot_cnt_o + 1'b1;
        end
    end

    // every preamble also passes through saturation briefly
    always_ff @(posedge clk) begin
        if (rst) begin
            tol_cnt <= '0;
        end else if (match || slot_cnt_o != spdif_pkg::SLOT_UNLOCKED) begin
            tol_cnt <= '0;
        end else if (halfbit_stb_i && tol_cnt != spdif_pkg::UNLOCK_TOLERANCE) begin
            tol_cnt <= tol_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            locked_o <= 1'b0;
        end else if (match) begin
            locked_o <= 1'b1;
        end else if (tol_cnt == spdif_pkg::UNLOCK_TOLERANCE) begin
            locked_o <= 1'b0; // line gone or way off rate
        end
    end

endmodule

`default_nettype wire

// File: spdif_decoder/spdif_subframe_capture.sv
`timescale 1ns/1ps
`default_nettype none

module spdif_subframe_capture (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              halfbit_stb_i,
    input  logic                              halfbit_lvl_i,
    input  logic                              pre_stb_i,
    input  spdif_pkg::preamble_t              pre_type_i,
    input  logic [spdif_pkg::SLOT_CNT_W-1:0]  slot_cnt_i,
    input  logic                              locked_i,
    output logic [spdif_pkg::SAMPLE_W-1:0]    sample_o,
    output logic                              sample_valid_o,
    output logic                              chan_b_o,
    output logic                              validity_o,
    output logic                              u_bit_o,
    output logic                              c_bit_o,
    output logic                              bits_stb_o,
    output spdif_pkg::preamble_t              bits_pre_o,
    output logic                              parity_err_o
);

    logic                               prev_lvl;
    logic                               dec_bit;
    logic                               dec_en;
    logic                               audio_done;
    logic                               sub_done;
    logic                               parity_q;
    logic [spdif_pkg::SAMPLE_W-1:0]     bit_sr;
    spdif_pkg::preamble_t               cur_pre;

    // biphase mark, a mid-bit transition means 1
    assign dec_bit = prev_lvl ^ halfbit_lvl_i;
    assign dec_en  = halfbit_stb_i && slot_cnt_i[0] && (slot_cnt_i <= spdif_pkg::SLOT_LAST);

    assign audio_done = dec_en && (slot_cnt_i == spdif_pkg::SLOT_LAST_AUDIO);
    assign sub_done   = dec_en && (slot_cnt_i == spdif_pkg::SLOT_LAST) && locked_i;

    always_ff @(posedge clk) begin
        if (halfbit_stb_i) begin
            prev_lvl <= halfbit_lvl_i;
        end
        if (dec_en) begin
            bit_sr <= {dec_bit, bit_sr[spdif_pkg::SAMPLE_W-1:1]}; // lsb first
            if (slot_cnt_i == spdif_pkg::SLOT_FIRST_BIT) begin
                parity_q <= dec_bit;
            end else begin
                parity_q <= parity_q ^ dec_bit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_pre <= spdif_pkg::PRE_NONE;
        end else if (pre_stb_i) begin
            cur_pre <= pre_type_i;
        end
    end

    always_ff @(posedge clk) begin
        if (audio_done) begin
            sample_o <= {dec_bit, bit_sr[spdif_pkg::SAMPLE_W-1:1]};
            chan_b_o <= (cur_pre == spdif_pkg::PRE_W);
        end
    end

    // V, U, C sit in the top of the shifter when P arrives
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_valid_o <= 1'b0;
            bits_stb_o     <= 1'b0;
            parity_err_o   <= 1'b0;
            validity_o     <= 1'b0;
            bits_pre_o     <= spdif_pkg::PRE_NONE;
        end else begin
            sample_valid_o <= audio_done && locked_i;
            bits_stb_o     <= sub_done;
            if (sub_done) begin
                validity_o   <= bit_sr[spdif_pkg::SAMPLE_W-3];
                parity_err_o <= parity_q ^ dec_bit; // even parity over 4..31
                bits_pre_o   <= cur_pre;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sub_done) begin
            u_bit_o <= bit_sr[spdif_pkg::SAMPLE_W-2];
            c_bit_o <= bit_sr[spdif_pkg::SAMPLE_W-1];
        end
    end

endmodule

`default_nettype wire

// File: logic/spdif_block_assembler.sv
`timescale 1ns/1ps
`default_nettype none

module spdif_block_assembler (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 bits_stb_i,
    input  spdif_pkg::preamble_t                 bits_pre_i,
    input  logic                                 c_bit_i,
    input  logic                                 u_bit_i,
    input  logic                                 pre_stb_i,
    input  spdif_pkg::preamble_t                 pre_type_i,
    input  logic                                 locked_i,
    output logic [spdif_pkg::BLOCK_FRAMES-1:0]   cstat_o,
    output logic [spdif_pkg::BLOCK_FRAMES-1:0]   udata_o,
    output logic                                 block_valid_o
);

    logic [spdif_pkg::BLOCK_FRAMES-1:0]  c_sr;
    logic [spdif_pkg::BLOCK_FRAMES-1:0]  u_sr;
    logic [spdif_pkg::BLOCK_CNT_W-1:0]   frame_cnt;
    logic                                chan_a;
    logic                                take_bits;
    logic                                block_start;

    assign chan_a      = (bits_pre_i == spdif_pkg::PRE_B) || (bits_pre_i == spdif_pkg::PRE_M);
    assign take_bits   = bits_stb_i && chan_a && locked_i;
    assign block_start = pre_stb_i && (pre_type_i == spdif_pkg::PRE_B);

    // frame 0 is shifted in first and ends up in the msb
    always_ff @(posedge clk) begin
        if (take_bits) begin
            c_sr <= {c_sr[spdif_pkg::BLOCK_FRAMES-2:0], c_bit_i};
            u_sr <= {u_sr[spdif_pkg::BLOCK_FRAMES-2:0], u_bit_i};
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !locked_i) begin
            frame_cnt <= '0;
        end else if (block_start) begin
            frame_cnt <= '0;
        end else if (take_bits && frame_cnt != '1) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cstat_o       <= '0;
            udata_o       <= '0;
            block_valid_o <= 1'b0;
        end else begin
            block_valid_o <= block_start &&
                             (frame_cnt == spdif_pkg::BLOCK_CNT_W'(spdif_pkg::BLOCK_FRAMES));
            if (block_start) begin
                cstat_o <= c_sr;
                udata_o <= u_sr;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/spdif_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module spdif_rx_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 spdif_i,
    input  logic [spdif_pkg::HALFBIT_CNT_W-1:0]  clk_per_halfbit_i,
    output logic [spdif_pkg::SAMPLE_W-1:0]       sample_o,
    output logic                                 sample_valid_o,
    output logic                                 chan_b_o,
    output logic                                 validity_o,
    output logic                                 parity_err_o,
    output logic                                 locked_o,
    output logic [spdif_pkg::BLOCK_FRAMES-1:0]   cstat_o,
    output logic [spdif_pkg::BLOCK_FRAMES-1:0]   udata_o,
    output logic                                 block_valid_o
);

    logic                                halfbit_stb;
    logic                                halfbit_lvl;
    logic                                pre_stb;
    spdif_pkg::preamble_t                pre_type;
    logic [spdif_pkg::SLOT_CNT_W-1:0]    slot_cnt;
    logic                                locked;
    logic                                bits_stb;
    spdif_pkg::preamble_t                bits_pre;
    logic                                c_bit;
    logic                                u_bit;

    assign locked_o = locked;

    spdif_halfbit_sampler sampler0 (
        .clk               (clk),
        .rst               (rst),
        .clk_per_halfbit_i (clk_per_halfbit_i),
        .line_i            (spdif_i),
        .halfbit_stb_o     (halfbit_stb),
        .halfbit_lvl_o     (halfbit_lvl)
    );

    spdif_frame_sync sync0 (
        .clk           (clk),
        .rst           (rst),
        .halfbit_stb_i (halfbit_stb),
        .halfbit_lvl_i (halfbit_lvl),
        .pre_stb_o     (pre_stb),
        .pre_type_o    (pre_type),
        .slot_cnt_o    (slot_cnt),
        .locked_o      (locked)
    );

    spdif_subframe_capture capture0 (
        .clk            (clk),
        .rst            (rst),
        .halfbit_stb_i  (halfbit_stb),
        .halfbit_lvl_i  (halfbit_lvl),
        .pre_stb_i      (pre_stb),
        .pre_type_i     (pre_type),
        .slot_cnt_i     (slot_cnt),
        .locked_i       (locked),
        .sample_o       (sample_o),
        .sample_valid_o (sample_valid_o),
        .chan_b_o       (chan_b_o),
        .validity_o     (validity_o),
        .u_bit_o        (u_bit),
        .c_bit_o        (c_bit),
        .bits_stb_o     (bits_stb),
        .bits_pre_o     (bits_pre),
        .parity_err_o   (parity_err_o)
    );

    spdif_block_assembler block0 (
        .clk           (clk),
        .rst           (rst),
        .bits_stb_i    (bits_stb),
        .bits_pre_i    (bits_pre),
        .c_bit_i       (c_bit),
        .u_bit_i       (u_bit),
        .pre_stb_i     (pre_stb),
        .pre_type_i    (pre_type),
        .locked_i      (locked),
        .cstat_o       (cstat_o),
        .udata_o       (udata_o),
        .block_valid_o (block_valid_o)
    );

endmodule

`default_nettype wire

// File: verif/spdif_rx_assert.sv
`timescale 1ns/1ps
`default_nettype none

module spdif_rx_assert (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              pre_stb_o,
    input  logic [spdif_pkg::SLOT_CNT_W-1:0]  slot_cnt_o,
    input  logic                              locked_o
);

    // a preamble keeps the receiver locked
    a_lock_holds: assert property (@(posedge clk) disable iff (rst)
        pre_stb_o |=> locked_o)
        else $error("lock lost right after a preamble");

    // out of lock the slot counter has run out
    a_unlocked_saturated: assert property (@(posedge clk) disable iff (rst)
        !locked_o |-> (slot_cnt_o == spdif_pkg::SLOT_UNLOCKED))
        else $error("unlocked while the slot counter was still running");

endmodule

`default_nettype wire

// File: verif/spdif_tx_model.sv
`timescale 1ns/1ps
`default_nettype none

module spdif_tx_model (
    input  logic                                 clk,
    input  logic [spdif_pkg::HALFBIT_CNT_W-1:0]  per_i,
    output logic                                 line_o
);

    logic lvl = 1'b0; // level of the last halfbit sent

    initial line_o <= 1'b0;

    task automatic drive_halfbit(input logic b);
        int i;
        lvl = b;
        for (i = 0; i < int'(per_i); i++) begin
            @(posedge clk);
            line_o <= b;
        end
    endtask

    // data[0] is bit 4 of the subframe, data[27] the P bit
    task automatic send_subframe(input spdif_pkg::preamble_t pre, input logic [27:0] data);
        logic [7:0] pat;
        int         i;
        case (pre)
            spdif_pkg::PRE_B: pat = spdif_pkg::SYNC_B;
            spdif_pkg::PRE_W: pat = spdif_pkg::SYNC_W;
            default:          pat = spdif_pkg::SYNC_M;
        endcase
        if (!lvl) begin
            pat = ~pat; // first halfbit must toggle the line
        end
        for (i = 7; i >= 0; i--) begin
            drive_halfbit(pat[i]);
        end
        for (i = 0; i < 28; i++) begin
            drive_halfbit(~lvl);
            if (data[i]) begin
                drive_halfbit(~lvl);
            end else begin
                drive_halfbit(lvl);
            end
        end
    endtask

    // line just holds its level
    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

endmodule

`default_nettype wire

// File: verif/spdif_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spdif_tb;

    typedef struct packed {
        logic [4:0]  per;
        logic [15:0] frames;
        logic [23:0] seed;
        logic [15:0] bad;   // frame whose channel A parity is flipped
        logic [15:0] gap;   // idle cycles after the run
    } run_row_t;

    logic                                 clk = 1'b0;
    logic                                 rst;
    logic                                 spdif;
    logic [spdif_pkg::HALFBIT_CNT_W-1:0]  per;
    logic [spdif_pkg::SAMPLE_W-1:0]       sample_o;
    logic                                 sample_valid_o;
    logic                                 chan_b_o;
    logic                                 validity_o;
    logic                                 parity_err_o;
    logic                                 locked_o;
    logic [spdif_pkg::BLOCK_FRAMES-1:0]   cstat_o;
    logic [spdif_pkg::BLOCK_FRAMES-1:0]   udata_o;
    logic                                 block_valid_o;

    run_row_t                             runs [3];
    logic [spdif_pkg::SAMPLE_W-1:0]       exp_sample [$];
    logic                                 exp_chan [$];
    logic                                 exp_valid [$];
    logic                                 exp_perr [$];
    logic [spdif_pkg::BLOCK_FRAMES-1:0]   exp_cstat [$];
    logic [spdif_pkg::BLOCK_FRAMES-1:0]   exp_udata [$];
    int                                   err_val = 0;
    int                                   err_other = 0;
    logic                                 timed_out = 1'b0;
    logic                                 pre_phase = 1'b1; // no preamble sent yet

    always #2 clk = ~clk;

    spdif_rx_top dut0 (
        .clk               (clk),
        .rst               (rst),
        .spdif_i           (spdif),
        .clk_per_halfbit_i (per),
        .sample_o          (sample_o),
        .sample_valid_o    (sample_valid_o),
        .chan_b_o          (chan_b_o),
        .validity_o        (validity_o),
        .parity_err_o      (parity_err_o),
        .locked_o          (locked_o),
        .cstat_o           (cstat_o),
        .udata_o           (udata_o),
        .block_valid_o     (block_valid_o)
    );

    spdif_tx_model tx0 (
        .clk    (clk),
        .per_i  (per),
        .line_o (spdif)
    );

    bind spdif_frame_sync spdif_rx_assert assert0 (
        .clk           (clk),
        .rst           (rst),
        .pre_stb_o     (pre_stb_o),
        .slot_cnt_o    (slot_cnt_o),
        .locked_o      (locked_o)
    );

    task automatic check_sample(input string name, input logic [spdif_pkg::SAMPLE_W-1:0] exp,
                                input logic [spdif_pkg::SAMPLE_W-1:0] got);
        if (got !== exp) begin
            $display("ERR %0t %s exp=%h got=%h", $time, name, exp, got);
            err_val++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("ERR %0t %s exp=%b got=%b", $time, name, exp, got);
            err_val++;
        end
    endtask

    task automatic check_block(input string name, input logic [spdif_pkg::BLOCK_FRAMES-1:0] exp,
                               input logic [spdif_pkg::BLOCK_FRAMES-1:0] got);
        if (got !== exp) begin
            $display("ERR %0t %s exp=%h got=%h", $time, name, exp, got);
            err_val++;
        end
    endtask

    task automatic report_and_finish();
        $display("errors: %0d wrong values, %0d other failures", err_val, err_other);
        if (err_val + err_other == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic wait_unlock(input int limit);
        int n;
        n = 0;
        while (locked_o && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (locked_o) begin
            $display("timeout: locked_o stayed high after the line went idle");
            err_other++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_drained(input int limit);
        int n;
        n = 0;
        while ((exp_sample.size() != 0 || exp_perr.size() != 0 || exp_cstat.size() != 0)
               && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (exp_sample.size() != 0 || exp_perr.size() != 0 || exp_cstat.size() != 0) begin
            $display("timeout: sent samples or blocks were never received");
            err_other++;
            timed_out = 1'b1;
        end
    endtask

    // outputs are compared half a cycle after the edge that set them
    always @(negedge clk) begin
        if (pre_phase) begin
            check_bit("locked_o", 1'b0, locked_o);
            check_bit("sample_valid_o", 1'b0, sample_valid_o);
            check_bit("block_valid_o", 1'b0, block_valid_o);
        end
        if (!rst && sample_valid_o) begin
            if (exp_sample.size() == 0) begin
                $display("sample_valid_o at %0t but no sample was sent", $time);
                err_other++;
            end else begin
                check_sample("sample_o", exp_sample.pop_front(), sample_o);
                check_bit("chan_b_o", exp_chan.pop_front(), chan_b_o);
            end
        end
        if (!rst && dut0.bits_stb) begin
            if (exp_perr.size() == 0) begin
                $display("subframe end at %0t but no subframe was sent", $time);
                err_other++;
            end else begin
                check_bit("validity_o", exp_valid.pop_front(), validity_o);
                check_bit("parity_err_o", exp_perr.pop_front(), parity_err_o);
            end
        end
        if (!rst && block_valid_o) begin
            if (exp_cstat.size() == 0) begin
                $display("block_valid_o at %0t without a complete block", $time);
                err_other++;
            end else begin
                check_block("cstat_o", exp_cstat.pop_front(), cstat_o);
                check_block("udata_o", exp_udata.pop_front(), udata_o);
            end
        end
    end

    initial begin
        int                                 r;
        int                                 f;
        int                                 ch;
        logic [31:0]                        rnd;
        logic [31:0]                        flags;
        logic [spdif_pkg::SAMPLE_W-1:0]     smp;
        logic                               p;
        logic                               bad;
        spdif_pkg::preamble_t               pre_a;
        logic [spdif_pkg::BLOCK_FRAMES-1:0] cur_c;
        logic [spdif_pkg::BLOCK_FRAMES-1:0] cur_u;

        // a full block then idle, the next block start must not report it
        runs[0] = '{per: 5'd8,  frames: 16'd192, seed: 24'h5a5a5a, bad: 16'd5,  gap: 16'd600};
        runs[1] = '{per: 5'd12, frames: 16'd20,  seed: 24'h0f1e2d, bad: 16'd3,  gap: 16'd800};
        runs[2] = '{per: 5'd8,  frames: 16'd196, seed: 24'hc3c3c3, bad: 16'd77, gap: 16'd600};
        void'($urandom(78));
        rst <= 1'b1;
        per <= 5'd8;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        tx0.idle(100);
        for (r = 0; r < 3 && !timed_out; r++) begin
            @(posedge clk);
            per <= runs[r].per;
            @(posedge clk);
            cur_c = '0;
            cur_u = '0;
            pre_phase = 1'b0;
            for (f = 0; f < int'(runs[r].frames); f++) begin
                pre_a = spdif_pkg::PRE_M;
                if (f % spdif_pkg::BLOCK_FRAMES == 0) begin
                    pre_a = spdif_pkg::PRE_B;
                    if (f > 0) begin
                        exp_cstat.push_back(cur_c);
                        exp_udata.push_back(cur_u);
                    end
                    cur_c = '0;
                    cur_u = '0;
                end
                for (ch = 0; ch < 2; ch++) begin
                    rnd = $urandom();
                    flags = $urandom();
                    smp = rnd[23:0] ^ runs[r].seed;
                    p = ^{flags[2:0], smp};
                    bad = (ch == 0) && (f == int'(runs[r].bad));
                    if (bad) begin
                        p = ~p;
                    end
                    exp_sample.push_back(smp);
                    exp_chan.push_back(ch == 1);
                    exp_valid.push_back(flags[0]);
                    exp_perr.push_back(bad);
                    if (ch == 0) begin
                        cur_c = {cur_c[spdif_pkg::BLOCK_FRAMES-2:0], flags[2]};
                        cur_u = {cur_u[spdif_pkg::BLOCK_FRAMES-2:0], flags[1]};
                        tx0.send_subframe(pre_a, {p, flags[2:0], smp});
                    end else begin
                        tx0.send_subframe(spdif_pkg::PRE_W, {p, flags[2:0], smp});
                    end
                end
            end
            tx0.idle(int'(runs[r].gap));
            wait_unlock(2000);
            if (!timed_out) begin
                wait_drained(2000);
            end
        end
        report_and_finish();
    end

endmodule

`default_nettype wire

// File: sim.f
common/spdif_pkg.sv
logic/spdif_halfbit_sampler.sv
spdif_decoder/spdif_frame_sync.sv
spdif_decoder/spdif_subframe_capture.sv
logic/spdif_block_assembler.sv
logic/spdif_rx_top.sv
verif/spdif_rx_assert.sv
verif/spdif_tx_model.sv
verif/spdif_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module spdif_tb -f sim.f -o spdif_sim

./obj_dir/spdif_sim | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0
